/* include/rom_fetch_settings.svh */
/*
    ROM fetch settings
    SDRAM layout, colour PROM location in the download stream,
    pixel clock-enable ratio and byte lane order
*/
`ifndef ROM_FETCH_SETTINGS_SVH
`define ROM_FETCH_SETTINGS_SVH

// SDRAM word offsets
`define MAIN_OFFSET 22'h00_0000
`define GFX_OFFSET  22'h01_0000   // Right after 128kB of main ROM

// Download stream byte address where the colour PROMs begin
`define PROM_START  25'h0A_0000

// Pixel enable is CEN_N/CEN_M of clk
`define CEN_N       10'd16
`define CEN_M       10'd125

// Even bytes land on the upper lane
`define DWNLD_SWAB  1'b1

`endif

/* hdl/rom_fetch_pkg.sv */
/*
    ROM fetch package
    SDRAM word views and slot controller states
*/
`default_nettype none

package rom_fetch_pkg;

    // Two byte lanes of one SDRAM word
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } sdram_bytes_t;

    // Graphics reads the whole word, main reads a single lane
    typedef union packed {
        logic [15:0]  word;
        sdram_bytes_t b;
    } sdram_word_u;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,       // sdram_req held high
        WAIT_DATA       // Waiting for data_rdy
    } ctrl_state_e;

endpackage

`default_nettype wire

/* hdl/frac_cen.sv */
/*
    Fractional clock enable
    Pixel enable at CEN_N/CEN_M of clk, plus enables at
    one half and one quarter of that rate
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_fetch_settings.svh"

module frac_cen (
    input  wire  clk,
    input  wire  rst,
    output logic pxl_cen,
    output logic pxl2_cen,  // Every second pxl_cen
    output logic pxl4_cen   // Every fourth pxl_cen
);

logic [10:0] acc;
logic [10:0] sum;
logic [ 1:0] div;

// One extra bit so the sum cannot wrap
assign sum = acc + {1'b0, `CEN_N};

always_ff @(posedge clk) begin
    if (rst) begin
        acc      <= 11'd0;
        div      <= 2'd0;
        pxl_cen  <= 1'b0;
        pxl2_cen <= 1'b0;
        pxl4_cen <= 1'b0;
    end else begin
        if (sum >= {1'b0, `CEN_M}) begin
            acc      <= sum - {1'b0, `CEN_M};
            div      <= div + 2'd1;
            pxl_cen  <= 1'b1;
            pxl2_cen <= div[0];
            pxl4_cen <= &div;   // Last step of the divide by 4
        end else begin
            acc      <= sum;
            pxl_cen  <= 1'b0;
            pxl2_cen <= 1'b0;
            pxl4_cen <= 1'b0;
        end
    end
end

endmodule

`default_nettype wire

/* hdl/rom_dwnld.sv */
/*
    ROM download
    Turns loader bytes into masked SDRAM writes, held until acked.
    Bytes in the colour PROM region give a one-cycle prom_we instead
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_fetch_settings.svh"

module rom_dwnld (
    input  wire         clk,
    input  wire         rst,
    input  wire         downloading,
    input  wire  [24:0] ioctl_addr,
    input  wire  [ 7:0] ioctl_dout,
    input  wire         ioctl_wr,
    input  wire         sdram_ack,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic [ 1:0] prog_mask,  // Active low
    output logic        prog_we,
    output logic        prom_we
);

logic        wr_en;
logic        is_prom;
logic        upper_lane;
logic [24:0] prom_offset;

assign wr_en       = ioctl_wr & downloading;
assign is_prom     = ioctl_addr >= `PROM_START;
assign prom_offset = ioctl_addr - `PROM_START;
assign upper_lane  = ioctl_addr[0] ^ `DWNLD_SWAB;

always_ff @(posedge clk) begin
    if (rst) begin
        prog_we <= 1'b0;
        prom_we <= 1'b0;
    end else begin
        prom_we <= wr_en & is_prom;     // Single pulse
        if (wr_en && !is_prom)
            prog_we <= 1'b1;
        else if (sdram_ack)
            prog_we <= 1'b0;
    end
end

// Write payload
always_ff @(posedge clk) begin
    if (wr_en) begin
        prog_data <= ioctl_dout;
        if (is_prom) begin
            prog_addr <= prom_offset[21:0];
            prog_mask <= 2'b11;
        end else begin
            prog_addr <= ioctl_addr[22:1];  // Byte to word address
            prog_mask <= upper_lane ? 2'b01 : 2'b10;
        end
    end
end

endmodule

`default_nettype wire

/* hdl/rom_slot_cache.sv */
/*
    ROM slot
    Keeps the last word fetched from SDRAM and its address.
    Hits answer in the same cycle, misses are flagged to the controller
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_fetch_settings.svh"

module rom_slot_cache
    import rom_fetch_pkg::*;
#(
    parameter int AW = 18,
    parameter int DW = 16
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                cs,
    input  wire       [AW-1:0] addr,
    input  wire                refill,
    input  sdram_word_u        refill_word,
    output logic               ok,
    output logic      [DW-1:0] dout,
    output logic               miss
);

logic [AW-1:0] cached_addr;
sdram_word_u   cached_word;
logic          valid;
logic          hit;

always_ff @(posedge clk) begin
    if (rst)
        valid <= 1'b0;
    else if (refill)
        valid <= 1'b1;
end

// Requester holds addr steady until ok
always_ff @(posedge clk) begin
    if (refill) begin
        cached_addr <= addr;
        cached_word <= refill_word;
    end
end

assign hit  = valid && cached_addr == addr;
assign ok   = cs & hit;
assign miss = cs & ~hit;

generate
    if (DW == 8) begin : g_byte
        // Byte lane picked by the address LSB
        assign dout = (addr[0] ^ `DWNLD_SWAB) ? cached_word.b.hi : cached_word.b.lo;
    end else begin : g_word
        assign dout = cached_word.word[DW-1:0];
    end
endgenerate

endmodule

`default_nettype wire

/* hdl/rom_slot_ctrl.sv */
/*
    ROM slot controller
    Fetches slot misses from SDRAM one at a time, graphics first,
    and strobes the refill of the slot that asked
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_fetch_settings.svh"

module rom_slot_ctrl
    import rom_fetch_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         downloading,
    input  wire         gfx_miss,
    input  wire  [17:0] gfx_addr,       // Word address
    input  wire         main_miss,
    input  wire  [16:0] main_addr,      // Byte address
    input  wire         sdram_ack,
    input  wire         data_rdy,
    input  wire  [15:0] data_read,
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    output logic        gfx_refill,
    output logic        main_refill,
    output sdram_word_u refill_word
);

ctrl_state_e state;
logic        serve_gfx;     // Slot being served
logic        start;
logic        done;

// No new requests while the loader owns the SDRAM
assign start = state == IDLE && !downloading && (gfx_miss || main_miss);
assign done  = state == WAIT_DATA && data_rdy;

always_ff @(posedge clk) begin
    if (rst) begin
        state     <= IDLE;
        sdram_req <= 1'b0;
        serve_gfx <= 1'b0;
    end else begin
        case (state)
            IDLE: begin
                if (start) begin
                    serve_gfx <= gfx_miss;  // Graphics wins a tie
                    sdram_req <= 1'b1;
                    state     <= WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (data_rdy)
                    state <= IDLE;
            end
            default: begin
                sdram_req <= 1'b0;
                state     <= IDLE;
            end
        endcase
    end
end

// SDRAM address, held until the ack
always_ff @(posedge clk) begin
    if (start) begin
        if (gfx_miss)
            sdram_addr <= {4'd0, gfx_addr} + `GFX_OFFSET;
        else
            sdram_addr <= {6'd0, main_addr[16:1]} + `MAIN_OFFSET;
    end
end

assign gfx_refill  = done & serve_gfx;
assign main_refill = done & ~serve_gfx;
assign refill_word = sdram_word_u'(data_read);  // Valid with data_rdy only

endmodule

`default_nettype wire

/* hdl/rom_fetch_top.sv */
/*
    ROM fetch top level
    Pixel enables, ROM download, graphics and main ROM slots
    and the SDRAM read controller that refills them
*/
`timescale 1ns/1ps
`default_nettype none

module rom_fetch_top
    import rom_fetch_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    // Clock enables
    output logic        pxl_cen,
    output logic        pxl2_cen,
    output logic        pxl4_cen,
    // Loader
    input  wire         downloading,
    input  wire  [24:0] ioctl_addr,
    input  wire  [ 7:0] ioctl_dout,
    input  wire         ioctl_wr,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic [ 1:0] prog_mask,  // Active low
    output logic        prog_we,
    output logic        prom_we,
    // Graphics ROM
    input  wire         gfx_cs,
    input  wire  [17:0] gfx_addr,
    output logic        gfx_ok,
    output logic [15:0] gfx_data,
    // Main CPU ROM
    input  wire         main_cs,
    input  wire  [16:0] main_addr,
    output logic        main_ok,
    output logic [ 7:0] main_data,
    // SDRAM
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    input  wire         sdram_ack,
    input  wire         data_rdy,
    input  wire  [15:0] data_read
);

logic        gfx_miss, main_miss;
logic        gfx_refill, main_refill;
sdram_word_u refill_word;

frac_cen u_cen (
    .clk        ( clk       ),
    .rst        ( rst       ),
    .pxl_cen    ( pxl_cen   ),
    .pxl2_cen   ( pxl2_cen  ),
    .pxl4_cen   ( pxl4_cen  )
);

rom_dwnld u_dwnld (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .ioctl_addr  ( ioctl_addr  ),
    .ioctl_dout  ( ioctl_dout  ),
    .ioctl_wr    ( ioctl_wr    ),
    .sdram_ack   ( sdram_ack   ),
    .prog_addr   ( prog_addr   ),
    .prog_data   ( prog_data   ),
    .prog_mask   ( prog_mask   ),
    .prog_we     ( prog_we     ),
    .prom_we     ( prom_we     )
);

rom_slot_cache #(.AW(18), .DW(16)) u_gfx (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .cs          ( gfx_cs      ),
    .addr        ( gfx_addr    ),
    .refill      ( gfx_refill  ),
    .refill_word ( refill_word ),
    .ok          ( gfx_ok      ),
    .dout        ( gfx_data    ),
    .miss        ( gfx_miss    )
);

rom_slot_cache #(.AW(17), .DW(8)) u_main (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .cs          ( main_cs     ),
    .addr        ( main_addr   ),
    .refill      ( main_refill ),
    .refill_word ( refill_word ),
    .ok          ( main_ok     ),
    .dout        ( main_data   ),
    .miss        ( main_miss   )
);

rom_slot_ctrl u_ctrl (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .gfx_miss    ( gfx_miss    ),
    .gfx_addr    ( gfx_addr    ),
    .main_miss   ( main_miss   ),
    .main_addr   ( main_addr   ),
    .sdram_ack   ( sdram_ack   ),
    .data_rdy    ( data_rdy    ),
    .data_read   ( data_read   ),
    .sdram_req   ( sdram_req   ),
    .sdram_addr  ( sdram_addr  ),
    .gfx_refill  ( gfx_refill  ),
    .main_refill ( main_refill ),
    .refill_word ( refill_word )
);

endmodule

`default_nettype wire

/* verification/rom_fetch_chk.sv */
/*
    Slot controller checker
    Concurrent assertions on the SDRAM request handshake
    and the refill strobes, bound into rom_slot_ctrl
*/
`timescale 1ns/1ps
`default_nettype none

module rom_fetch_chk (
    input wire         clk,
    input wire         rst,
    input wire         downloading,
    input wire         sdram_req,
    input wire         sdram_ack,
    input wire         gfx_refill,
    input wire         main_refill
);

int fail_cnt = 0;   // Read by the testbench

a_req_hold: assert property (@(posedge clk) disable iff (rst)
    sdram_req && !sdram_ack |=> sdram_req)
    else begin
        $error("sdram_req dropped before sdram_ack");
        fail_cnt = fail_cnt + 1;
    end

// Loader owns the SDRAM while downloading
a_no_req_dl: assert property (@(posedge clk) disable iff (rst)
    !sdram_req && downloading |=> !sdram_req)
    else begin
        $error("sdram_req rose while downloading");
        fail_cnt = fail_cnt + 1;
    end

a_one_refill: assert property (@(posedge clk) disable iff (rst)
    !(gfx_refill && main_refill))
    else begin
        $error("Both refill strobes high");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind rom_slot_ctrl rom_fetch_chk u_chk (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .sdram_req   ( sdram_req   ),
    .sdram_ack   ( sdram_ack   ),
    .gfx_refill  ( gfx_refill  ),
    .main_refill ( main_refill )
);

`default_nettype wire

/* verification/rom_fetch_monitor.sv */
/*
    ROM fetch monitor
    Watches the DUT ports, checks download writes, PROM pulses,
    slot read data, request order and clock enable rates
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_fetch_settings.svh"

module rom_fetch_monitor (
    input  wire        clk,
    input  wire        rst,
    input  wire        pxl_cen,
    input  wire        pxl2_cen,
    input  wire        pxl4_cen,
    input  wire        downloading,
    input  wire [24:0] ioctl_addr,
    input  wire [ 7:0] ioctl_dout,
    input  wire        ioctl_wr,
    input  wire [21:0] prog_addr,
    input  wire [ 7:0] prog_data,
    input  wire [ 1:0] prog_mask,
    input  wire        prog_we,
    input  wire        prom_we,
    input  wire        gfx_cs,
    input  wire [17:0] gfx_addr,
    input  wire        gfx_ok,
    input  wire [15:0] gfx_data,
    input  wire        main_cs,
    input  wire        main_ok,
    input  wire [ 7:0] main_data,
    input  wire        sdram_req,
    input  wire [21:0] sdram_addr,
    input  wire        sdram_ack,
    input  wire [15:0] exp_gfx,     // From the test data
    input  wire [ 7:0] exp_main,
    input  wire        no_fetch,    // Current read must hit
    input  wire        both_miss,   // Both slots asked together
    output int         err_count,
    output logic       cen_done
);

logic        pend_prog, pend_prom, prev_we, prev_ack, prev_req, first_seen;
logic [21:0] exp_addr, hold_addr;
logic [ 7:0] exp_data, hold_data;
logic [ 1:0] exp_mask, hold_mask;
logic [24:0] offset;
int          cyc, n1, n2, n4;

initial err_count = 0;

task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_count = err_count + 1;
endtask

function automatic bit within_one(input int got, input int want);
    return got >= want - 1 && got <= want + 1;
endfunction

assign offset = ioctl_addr - `PROM_START;

always @(posedge clk) begin
    if (rst) begin
        pend_prog  <= 1'b0;
        pend_prom  <= 1'b0;
        prev_we    <= 1'b0;
        prev_ack   <= 1'b0;
        prev_req   <= 1'b0;
        first_seen <= 1'b0;
        cen_done   <= 1'b0;
        cyc = 0;
        n1 = 0;
        n2 = 0;
        n4 = 0;
    end else begin
        if (pend_prog) begin
            if (!prog_we || prog_addr !== exp_addr || prog_data !== exp_data
                    || prog_mask !== exp_mask)
                report_error($sformatf("prog write %h/%h/%b, expected %h/%h/%b",
                    prog_addr, prog_data, prog_mask, exp_addr, exp_data, exp_mask));
        end else if (prog_we && !prev_we) begin
            report_error("prog_we rose without a loader write");
        end
        if (prev_we && !prev_ack && (!prog_we || prog_addr !== hold_addr
                || prog_data !== hold_data || prog_mask !== hold_mask))
            report_error("prog write changed before sdram_ack");
        if (pend_prom) begin
            if (!prom_we || prog_we || prog_addr !== exp_addr)
                report_error($sformatf("PROM write at %h, expected %h", prog_addr, exp_addr));
        end else if (prom_we) begin
            report_error("prom_we without a PROM write");
        end
        if (gfx_cs && gfx_ok && gfx_data !== exp_gfx)
            report_error($sformatf("gfx_data %h, expected %h", gfx_data, exp_gfx));
        if (main_cs && main_ok && main_data !== exp_main)
            report_error($sformatf("main_data %h, expected %h", main_data, exp_main));
        if (no_fetch && sdram_req)
            report_error("SDRAM request on a repeated read");
        // Graphics must be fetched first
        if (both_miss && sdram_req && !prev_req && !first_seen) begin
            if (sdram_addr !== {4'd0, gfx_addr} + `GFX_OFFSET)
                report_error($sformatf("first request %h is not the graphics one", sdram_addr));
            first_seen <= 1'b1;
        end else if (!both_miss) begin
            first_seen <= 1'b0;
        end

        // Loader write seen now, outputs expected on the next edge
        pend_prog <= ioctl_wr && downloading && ioctl_addr < `PROM_START;
        pend_prom <= ioctl_wr && downloading && ioctl_addr >= `PROM_START;
        if (ioctl_wr && downloading) begin
            exp_data <= ioctl_dout;
            if (ioctl_addr >= `PROM_START) begin
                exp_addr <= offset[21:0];
            end else begin
                exp_addr <= ioctl_addr[22:1];
                exp_mask <= (ioctl_addr[0] ^ `DWNLD_SWAB) ? 2'b01 : 2'b10;
            end
        end
        prev_we   <= prog_we;
        prev_ack  <= sdram_ack;
        prev_req  <= sdram_req;
        hold_addr <= prog_addr;
        hold_data <= prog_data;
        hold_mask <= prog_mask;

        // Enable rates over 2000 cycles
        if (cyc < 2000) begin
            n1 = n1 + int'(pxl_cen);
            n2 = n2 + int'(pxl2_cen);
            n4 = n4 + int'(pxl4_cen);
            cyc = cyc + 1;
            if (cyc == 2000) begin
                if (!within_one(n1, 256) || !within_one(n2, 128) || !within_one(n4, 64))
                    report_error($sformatf("cen counts %0d/%0d/%0d, expected 256/128/64",
                        n1, n2, n4));
                cen_done <= 1'b1;
            end
        end
    end
end

endmodule

`default_nettype wire

/* verification/rom_fetch_tb.sv */
/*
    ROM fetch testbench
    Clock, reset, SDRAM model and stimulus read from the test data file
*/
`timescale 1ns/1ps
`default_nettype none

`include "rom_fetch_settings.svh"

module rom_fetch_tb;

logic        clk = 1'b0;
logic        rst, downloading, ioctl_wr, gfx_cs, main_cs;
logic [24:0] ioctl_addr;
logic [ 7:0] ioctl_dout, exp_main;
logic [17:0] gfx_addr;
logic [16:0] main_addr;
logic [15:0] exp_gfx;
logic        no_fetch, both_miss;
logic        sdram_ack = 1'b0;
logic        data_rdy = 1'b0;
logic [15:0] data_read = 16'h0;
logic        pxl_cen, pxl2_cen, pxl4_cen, prog_we, prom_we, gfx_ok, main_ok, sdram_req;
logic [21:0] prog_addr, sdram_addr, rd_addr;
logic [ 7:0] prog_data, main_data;
logic [ 1:0] prog_mask;
logic [15:0] gfx_data, word;
logic [15:0] mem [logic [21:0]];    // Sparse SDRAM
int          err_count, seed, wait_cnt, rd_cnt, cycles, limit, fd, code, i;
logic        cen_done, rd_pend;
string       kind, line;
string       kinds[$];
int          va[$], vb[$], vc[$], vd[$];
int          a, b, c, d;

always #20 clk = ~clk;

rom_fetch_top i_dut (.*);

rom_fetch_monitor u_mon (.*);

// SDRAM model, ack after 0 to 3 cycles
always @(negedge clk) begin
    sdram_ack <= 1'b0;
    data_rdy  <= 1'b0;
    if (rst) begin
        rd_pend  = 1'b0;
        wait_cnt = $unsigned($random(seed)) % 4;
    end else if (rd_pend) begin
        if (rd_cnt == 0) begin
            data_rdy  <= 1'b1;
            data_read <= mem.exists(rd_addr) ? mem[rd_addr] : 16'h0;
            rd_pend = 1'b0;
        end else begin
            rd_cnt = rd_cnt - 1;
        end
    end else if ((prog_we || sdram_req) && !sdram_ack) begin
        if (wait_cnt == 0) begin
            sdram_ack <= 1'b1;
            if (prog_we) begin
                word = mem.exists(prog_addr) ? mem[prog_addr] : 16'h0;
                if (!prog_mask[1])
                    word[15:8] = prog_data;
                if (!prog_mask[0])
                    word[7:0] = prog_data;
                mem[prog_addr] = word;
            end else begin
                rd_pend = 1'b1;
                rd_addr = sdram_addr;
                rd_cnt  = $unsigned($random(seed)) % 4;
            end
            wait_cnt = $unsigned($random(seed)) % 4;
        end else begin
            wait_cnt = wait_cnt - 1;
        end
    end
end

always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
        $display("Timeout: the test did not finish within %0d cycles", limit);
        $display("=== FAIL ===");
        $finish;
    end
end

task automatic loader_write(input int addr, input int data);
    @(negedge clk);
    ioctl_addr = addr[24:0];
    ioctl_dout = data[7:0];
    ioctl_wr   = 1'b1;
    @(negedge clk);
    ioctl_wr = 1'b0;
    while (prog_we)
        @(negedge clk);
endtask

task automatic slot_read(input bit use_gfx, input bit use_main);
    bit seen_gfx, seen_main;
    seen_gfx  = !use_gfx;
    seen_main = !use_main;
    @(negedge clk);
    gfx_cs  = use_gfx;
    main_cs = use_main;
    while (!(seen_gfx && seen_main)) begin
        @(negedge clk);
        seen_gfx  = seen_gfx || gfx_ok;
        seen_main = seen_main || main_ok;
    end
    @(negedge clk);     // Keep cs up across one more rising edge with ok high
    gfx_cs    = 1'b0;
    main_cs   = 1'b0;
    no_fetch  = 1'b0;
    both_miss = 1'b0;
endtask

initial begin
    seed = 8;
    cycles = 0;
    limit = 2000;
    rst = 1'b1;
    downloading = 1'b0;
    ioctl_wr = 1'b0;
    ioctl_addr = 25'd0;
    ioctl_dout = 8'd0;
    gfx_cs = 1'b0;
    gfx_addr = 18'd0;
    main_cs = 1'b0;
    main_addr = 17'd0;
    exp_gfx = 16'd0;
    exp_main = 8'd0;
    no_fetch = 1'b0;
    both_miss = 1'b0;
    fd = $fopen("verification/rom_fetch_testdata.txt", "r");
    if (fd == 0) begin
        $display("Could not open the test data file");
        $display("=== FAIL ===");
        $finish;
    end else begin
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", kind);
            if (code != 1)
                break;
            a = 0;
            b = 0;
            c = 0;
            d = 0;
            if (kind == "#")
                code = $fgets(line, fd);
            else if (kind == "B")
                code = $fscanf(fd, " %h %h %h %h", a, b, c, d);
            else
                code = $fscanf(fd, " %h %h", a, b);
            if (kind != "#") begin
                kinds.push_back(kind);
                va.push_back(a);
                vb.push_back(b);
                vc.push_back(c);
                vd.push_back(d);
            end
        end
        $fclose(fd);
        limit = 40 * kinds.size() + 2000;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        downloading = 1'b1;
        for (i = 0; i < kinds.size(); i++) begin
            if (kinds[i] == "D" || kinds[i] == "P") begin
                loader_write(va[i], vb[i]);
            end else begin
                if (downloading) begin
                    @(negedge clk);
                    downloading = 1'b0;
                end
                if (kinds[i] == "G") begin
                    gfx_addr = va[i][17:0];
                    exp_gfx  = vb[i][15:0];
                    slot_read(1'b1, 1'b0);
                end else if (kinds[i] == "B") begin
                    gfx_addr  = va[i][17:0];
                    exp_gfx   = vb[i][15:0];
                    main_addr = vc[i][16:0];
                    exp_main  = vd[i][7:0];
                    both_miss = 1'b1;
                    slot_read(1'b1, 1'b1);
                end else begin
                    main_addr = va[i][16:0];
                    exp_main  = vb[i][7:0];
                    no_fetch  = kinds[i] == "H";
                    slot_read(1'b0, 1'b1);
                end
            end
        end
        while (!cen_done)
            @(negedge clk);
        @(negedge clk);
        $display("Errors: monitor %0d, assertions %0d", err_count, i_dut.u_ctrl.u_chk.fail_cnt);
        if (err_count == 0 && i_dut.u_ctrl.u_chk.fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end
end

endmodule

`default_nettype wire

/* verification/rom_fetch_testdata.txt */
# D, P: ioctl byte address, data byte (ROM download, colour PROM)
# G, M, H: slot address, expected data (H must hit); B: gfx addr, gfx data, main addr, main data
D 000000 12
D 000001 34
D 000002 56
D 000003 78
D 000010 9A
D 000011 BC
D 020000 A1
D 020001 B2
D 020002 C3
D 020003 D4
D 020020 E5
D 020021 F6
P 0A0000 0F
P 0A0005 3C
G 00000 A1B2
G 00001 C3D4
M 00000 12
M 00001 34
H 00001 34
M 00003 78
B 00010 E5F6 00010 9A
M 00011 BC

/* rom_fetch_top.f */
+incdir+include
hdl/rom_fetch_pkg.sv
hdl/frac_cen.sv
hdl/rom_dwnld.sv
hdl/rom_slot_cache.sv
hdl/rom_slot_ctrl.sv
hdl/rom_fetch_top.sv
verification/rom_fetch_chk.sv
verification/rom_fetch_monitor.sv
verification/rom_fetch_tb.sv

/* Makefile */
SIM = obj_dir/Vrom_fetch_tb

all: run

$(SIM): rom_fetch_top.f $(wildcard include/*.svh hdl/*.sv verification/*.sv)
	verilator --binary --timing --assert --top-module rom_fetch_tb -f rom_fetch_top.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
